// ==== dcache_pkg.sv ====
package dcache_pkg;

    // geometry
    localparam int DC_INDEX_W    = 4;
    localparam int DC_WORD_OFF_W = 2;
    localparam int DC_OFF_W      = DC_WORD_OFF_W + 2;        // byte offset inside a line
    localparam int DC_TAG_W      = 32 - DC_INDEX_W - DC_OFF_W;
    localparam int DC_SETS       = 1 << DC_INDEX_W;
    localparam int DC_WORDS      = 1 << DC_WORD_OFF_W;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [31:0] addr_t;
    typedef logic [DC_INDEX_W-1:0] index_t;

    // word 0 sits in the low bits
    typedef word_t [DC_WORDS-1:0] line_t;

    typedef struct packed {
        logic                valid;
        logic [DC_TAG_W-1:0] tag;
    } tag_entry_t;

endpackage

// ==== dcache_ifs.sv ====
// request buffer <-> main control
interface dc_req_if;
    logic                  req_pending;
    dcache_pkg::addr_t     req_addr;
    logic                  req_we;
    dcache_pkg::index_t    look_index;     // index the arrays read this cycle
    logic                  take;
    logic                  done;
    dcache_pkg::line_t     hit_line;
    dcache_pkg::line_t     merged_line;    // hit_line with store bytes applied

    modport front (
        output req_pending, req_addr, req_we, look_index, merged_line,
        input  take, done, hit_line
    );
    modport ctrl (
        input  req_pending, req_addr, req_we, look_index, merged_line,
        output take, done, hit_line
    );
endinterface

// line refill from memory
interface dc_refill_if;
    logic                  start;
    dcache_pkg::addr_t     line_addr;
    logic                  busy;
    logic                  done;
    dcache_pkg::line_t     line;

    modport ctrl   (output start, line_addr, input  busy, done, line);
    modport refill (input  start, line_addr, output busy, done, line);
endinterface

// dirty victim write-back
interface dc_wb_if;
    logic                  start;
    dcache_pkg::addr_t     victim_addr;
    dcache_pkg::line_t     victim_line;
    logic                  busy;
    logic                  done;

    modport ctrl (output start, victim_addr, victim_line, input  busy, done);
    modport wb   (input  start, victim_addr, victim_line, output busy, done);
endinterface

// ==== dcache_way_ram.sv ====
module dcache_way_ram #(
    parameter type T = dcache_pkg::line_t
) (
    input  logic               clk,
    input  logic               i_we,
    input  dcache_pkg::index_t i_windex,
    input  T                   i_wdata,
    input  dcache_pkg::index_t i_rindex,
    output T                   o_rdata
);

    T mem [dcache_pkg::DC_SETS];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_windex] <= i_wdata;      // whole entry written
        end
        o_rdata <= mem[i_rindex];          // old data on same-index write
    end

endmodule

// ==== dcache_req_front.sv ====
module dcache_req_front (
    input  logic              clk,
    input  logic              rstn,
    input  logic              i_rvalid,
    input  logic              i_wvalid,
    input  dcache_pkg::addr_t i_addr,
    input  dcache_pkg::word_t i_wdata,
    input  dcache_pkg::strb_t i_wstrb,
    output dcache_pkg::word_t o_rdata,
    dc_req_if.front           req
);

    logic                             held_q;
    dcache_pkg::addr_t                addr_q;
    dcache_pkg::word_t                data_q;
    dcache_pkg::strb_t                strb_q;
    logic [dcache_pkg::DC_WORD_OFF_W-1:0] woff;
    dcache_pkg::line_t                merged;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            held_q <= 1'b0;
        end else if (req.take) begin
            held_q <= 1'b1;
        end else if (req.done) begin
            held_q <= 1'b0;
        end
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (req.take) begin
            addr_q <= i_addr;
            data_q <= i_wdata;
            strb_q <= i_wvalid ? i_wstrb : '0;   // loads carry no strobe
        end
    end

    assign req.req_pending = held_q | i_rvalid | i_wvalid;
    assign req.req_addr    = addr_q;
    assign req.req_we      = |strb_q;

    // arrays follow the input while nothing is held
    assign req.look_index = held_q ? addr_q[dcache_pkg::DC_OFF_W +: dcache_pkg::DC_INDEX_W]
                                   : i_addr[dcache_pkg::DC_OFF_W +: dcache_pkg::DC_INDEX_W];

    assign woff = addr_q[2 +: dcache_pkg::DC_WORD_OFF_W];

    // store merge, byte by byte
    always_comb begin
        merged = req.hit_line;
        for (int b = 0; b < 4; b++) begin
            if (strb_q[b]) begin
                merged[woff][8*b +: 8] = data_q[8*b +: 8];
            end
        end
    end

    assign req.merged_line = merged;
    assign o_rdata         = req.hit_line[woff];

endmodule

// ==== dcache_ctrl.sv ====
module dcache_ctrl (
    input  logic                   clk,
    input  logic                   rstn,
    output logic                   o_rready,
    output logic                   o_wready,
    dc_req_if.ctrl                 req,
    dc_refill_if.ctrl              rf,
    dc_wb_if.ctrl                  wb,
    output logic [1:0]             o_tag_we,
    output dcache_pkg::tag_entry_t o_tag_wdata,
    input  dcache_pkg::tag_entry_t i_tag_rdata [2],
    output logic [1:0]             o_data_we,
    output dcache_pkg::line_t      o_data_wdata,
    input  dcache_pkg::line_t      i_data_rdata [2]
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_MISS,
        S_FILL,      // refill write
        S_FINISH
    } state_t;

    state_t state_q, state_d;

    logic [1:0][dcache_pkg::DC_SETS-1:0] valid_q;
    logic [1:0][dcache_pkg::DC_SETS-1:0] dirty_q;
    logic [dcache_pkg::DC_SETS-1:0]      lru_q;    // way to replace next
    logic                                vic_q;
    logic                                rf_ok_q;
    logic                                wb_ok_q;

    dcache_pkg::index_t            idx;
    logic [dcache_pkg::DC_TAG_W-1:0] tag;
    logic [1:0]                    hit;
    logic                          hit_any;
    logic                          hit_way;
    logic                          vic;
    logic                          vic_dirty;
    logic                          miss_go;
    logic                          fill_go;

    assign idx = req.req_addr[dcache_pkg::DC_OFF_W +: dcache_pkg::DC_INDEX_W];
    assign tag = req.req_addr[31 -: dcache_pkg::DC_TAG_W];

    // tag compare in the lookup cycle
    assign hit[0]  = valid_q[0][idx] && i_tag_rdata[0].valid && (i_tag_rdata[0].tag == tag);
    assign hit[1]  = valid_q[1][idx] && i_tag_rdata[1].valid && (i_tag_rdata[1].tag == tag);
    assign hit_any = |hit;
    assign hit_way = hit[1];

    assign vic       = lru_q[idx];
    assign vic_dirty = valid_q[vic][idx] && dirty_q[vic][idx];

    // units must be free before a miss goes out
    assign miss_go = (state_q == S_LOOKUP) && !hit_any && !rf.busy && !wb.busy;
    assign fill_go = (state_q == S_MISS) && (rf_ok_q || rf.done) && (wb_ok_q || wb.done);

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:   if (req.req_pending) state_d = S_LOOKUP;
            S_LOOKUP: begin
                if (hit_any) begin
                    state_d = S_IDLE;
                end else if (miss_go) begin
                    state_d = S_MISS;
                end
            end
            S_MISS:   if (fill_go) state_d = S_FILL;
            S_FILL:   state_d = S_FINISH;
            S_FINISH: state_d = S_IDLE;
            default:  state_d = S_IDLE;
        endcase
    end

    assign req.take = (state_q == S_IDLE) && req.req_pending;
    assign req.done = ((state_q == S_LOOKUP) && hit_any) || (state_q == S_FINISH);
    assign o_rready = req.done && !req.req_we;
    assign o_wready = req.done && req.req_we;

    // refilled line stays in the return buffer until the next miss
    assign req.hit_line = (state_q == S_LOOKUP) ? i_data_rdata[hit_way] : rf.line;

    assign rf.start     = miss_go;
    assign rf.line_addr = {req.req_addr[31:dcache_pkg::DC_OFF_W], {dcache_pkg::DC_OFF_W{1'b0}}};

    assign wb.start       = miss_go && vic_dirty;
    assign wb.victim_addr = {i_tag_rdata[vic].tag, idx, {dcache_pkg::DC_OFF_W{1'b0}}};
    assign wb.victim_line = i_data_rdata[vic];

    assign o_tag_we          = (state_q == S_FILL) ? (2'b01 << vic_q) : 2'b00;
    assign o_tag_wdata.valid = 1'b1;
    assign o_tag_wdata.tag   = tag;

    always_comb begin
        o_data_we = 2'b00;
        if (state_q == S_FILL) begin
            o_data_we = 2'b01 << vic_q;
        end else if (state_q == S_LOOKUP && req.req_we) begin
            o_data_we = hit;                 // store hit
        end
    end
    assign o_data_wdata = req.merged_line;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= S_IDLE;
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
            vic_q   <= 1'b0;
            rf_ok_q <= 1'b0;
            wb_ok_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (miss_go) begin
                vic_q   <= vic;
                rf_ok_q <= 1'b0;
                wb_ok_q <= !vic_dirty;       // clean victim needs no write-back
            end
            if (state_q == S_MISS) begin
                if (rf.done) rf_ok_q <= 1'b1;
                if (wb.done) wb_ok_q <= 1'b1;
            end
            if (state_q == S_LOOKUP && hit_any) begin
                lru_q[idx] <= !hit_way;
                if (req.req_we) dirty_q[hit_way][idx] <= 1'b1;
            end
            if (state_q == S_FILL) begin
                valid_q[vic_q][idx] <= 1'b1;
                dirty_q[vic_q][idx] <= req.req_we;
                lru_q[idx]          <= !vic_q;
            end
        end
    end

endmodule

// ==== dcache_refill.sv ====
module dcache_refill (
    input  logic              clk,
    input  logic              rstn,
    dc_refill_if.refill       rf,
    output logic              o_mem_rd_req,
    output dcache_pkg::addr_t o_mem_rd_addr,
    input  logic              i_mem_rd_valid,
    input  dcache_pkg::word_t i_mem_rd_data,
    input  logic              i_mem_rd_last
);

    logic              busy_q;
    logic              done_q;
    dcache_pkg::addr_t addr_q;
    dcache_pkg::line_t line_q;    // return buffer

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= busy_q && i_mem_rd_valid && i_mem_rd_last;
            if (rf.start) begin
                busy_q <= 1'b1;
            end else if (i_mem_rd_valid && i_mem_rd_last) begin
                busy_q <= 1'b0;              // request drops after the last beat
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rf.start) addr_q <= rf.line_addr;
        // beats shift down so word 0 ends in the low slot
        if (busy_q && i_mem_rd_valid) begin
            line_q <= {i_mem_rd_data, line_q[dcache_pkg::DC_WORDS-1:1]};
        end
    end

    assign o_mem_rd_req  = busy_q;
    assign o_mem_rd_addr = addr_q;
    assign rf.busy       = busy_q;
    assign rf.done       = done_q;
    assign rf.line       = line_q;

endmodule

// ==== dcache_writeback.sv ====
module dcache_writeback (
    input  logic              clk,
    input  logic              rstn,
    dc_wb_if.wb               wb,
    output logic              o_mem_wr_valid,
    input  logic              i_mem_wr_ready,
    output dcache_pkg::addr_t o_mem_wr_addr,
    output dcache_pkg::word_t o_mem_wr_data,
    output logic              o_mem_wr_last,
    input  logic              i_mem_wr_done
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_SEND,
        W_WAIT
    } wstate_t;

    wstate_t                              state_q;
    logic [dcache_pkg::DC_WORD_OFF_W-1:0] beat_q;
    dcache_pkg::line_t                    line_q;
    dcache_pkg::addr_t                    addr_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= W_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                W_IDLE: begin
                    if (wb.start) begin
                        state_q <= W_SEND;
                        beat_q  <= '0;
                    end
                end
                W_SEND: begin
                    if (i_mem_wr_ready) begin
                        beat_q <= beat_q + 1'b1;
                        if (&beat_q) state_q <= W_WAIT;   // last word gone
                    end
                end
                W_WAIT:  if (i_mem_wr_done) state_q <= W_IDLE;
                default: state_q <= W_IDLE;
            endcase
        end
    end

    // victim copy, the way may be refilled meanwhile
    always_ff @(posedge clk) begin
        if (wb.start && state_q == W_IDLE) begin
            line_q <= wb.victim_line;
            addr_q <= wb.victim_addr;
        end
    end

    assign o_mem_wr_valid = (state_q == W_SEND);
    assign o_mem_wr_last  = (state_q == W_SEND) && (&beat_q);
    assign o_mem_wr_data  = line_q[beat_q];
    assign o_mem_wr_addr  = addr_q;

    assign wb.busy = (state_q != W_IDLE);
    assign wb.done = (state_q == W_WAIT) && i_mem_wr_done;

endmodule

// ==== dcache_top.sv ====
module dcache_top (
    input  logic              clk,
    input  logic              rstn,
    input  logic              i_rvalid,
    input  logic              i_wvalid,
    input  dcache_pkg::addr_t i_addr,
    input  dcache_pkg::word_t i_wdata,
    input  dcache_pkg::strb_t i_wstrb,
    output logic              o_rready,
    output logic              o_wready,
    output dcache_pkg::word_t o_rdata,
    output logic              o_mem_rd_req,
    output dcache_pkg::addr_t o_mem_rd_addr,
    input  logic              i_mem_rd_valid,
    input  dcache_pkg::word_t i_mem_rd_data,
    input  logic              i_mem_rd_last,
    output logic              o_mem_wr_valid,
    input  logic              i_mem_wr_ready,
    output dcache_pkg::addr_t o_mem_wr_addr,
    output dcache_pkg::word_t o_mem_wr_data,
    output logic              o_mem_wr_last,
    input  logic              i_mem_wr_done
);

    dc_req_if    req_bus ();
    dc_refill_if rf_bus ();
    dc_wb_if     wb_bus ();

    logic [1:0]                  tag_we;
    dcache_pkg::tag_entry_t      tag_wdata;
    wire dcache_pkg::tag_entry_t tag_rdata [2];
    logic [1:0]                  data_we;
    dcache_pkg::line_t           data_wdata;
    wire dcache_pkg::line_t      data_rdata [2];

    dcache_req_front i_front (
        .clk      (clk),
        .rstn     (rstn),
        .i_rvalid (i_rvalid),
        .i_wvalid (i_wvalid),
        .i_addr   (i_addr),
        .i_wdata  (i_wdata),
        .i_wstrb  (i_wstrb),
        .o_rdata  (o_rdata),
        .req      (req_bus.front)
    );

    dcache_ctrl i_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .o_rready     (o_rready),
        .o_wready     (o_wready),
        .req          (req_bus.ctrl),
        .rf           (rf_bus.ctrl),
        .wb           (wb_bus.ctrl),
        .o_tag_we     (tag_we),
        .o_tag_wdata  (tag_wdata),
        .i_tag_rdata  (tag_rdata),
        .o_data_we    (data_we),
        .o_data_wdata (data_wdata),
        .i_data_rdata (data_rdata)
    );

    // tag and data array per way, written at the buffered index
    for (genvar w = 0; w < 2; w++) begin : g_way
        dcache_way_ram #(.T(dcache_pkg::tag_entry_t)) i_tag_ram (
            .clk      (clk),
            .i_we     (tag_we[w]),
            .i_windex (req_bus.req_addr[dcache_pkg::DC_OFF_W +: dcache_pkg::DC_INDEX_W]),
            .i_wdata  (tag_wdata),
            .i_rindex (req_bus.look_index),
            .o_rdata  (tag_rdata[w])
        );

        dcache_way_ram #(.T(dcache_pkg::line_t)) i_data_ram (
            .clk      (clk),
            .i_we     (data_we[w]),
            .i_windex (req_bus.req_addr[dcache_pkg::DC_OFF_W +: dcache_pkg::DC_INDEX_W]),
            .i_wdata  (data_wdata),
            .i_rindex (req_bus.look_index),
            .o_rdata  (data_rdata[w])
        );
    end

    dcache_refill i_refill (
        .clk            (clk),
        .rstn           (rstn),
        .rf             (rf_bus.refill),
        .o_mem_rd_req   (o_mem_rd_req),
        .o_mem_rd_addr  (o_mem_rd_addr),
        .i_mem_rd_valid (i_mem_rd_valid),
        .i_mem_rd_data  (i_mem_rd_data),
        .i_mem_rd_last  (i_mem_rd_last)
    );

    dcache_writeback i_wb (
        .clk            (clk),
        .rstn           (rstn),
        .wb             (wb_bus.wb),
        .o_mem_wr_valid (o_mem_wr_valid),
        .i_mem_wr_ready (i_mem_wr_ready),
        .o_mem_wr_addr  (o_mem_wr_addr),
        .o_mem_wr_data  (o_mem_wr_data),
        .o_mem_wr_last  (o_mem_wr_last),
        .i_mem_wr_done  (i_mem_wr_done)
    );

endmodule

// ==== dcache_props.sv ====
module dcache_props (
    input logic              clk,
    input logic              rstn,
    input logic              i_rvalid,
    input logic              i_wvalid,
    input logic              o_rready,
    input logic              o_wready,
    input logic              o_mem_rd_req,
    input dcache_pkg::addr_t o_mem_rd_addr,
    input logic              o_mem_wr_valid,
    input dcache_pkg::addr_t o_mem_wr_addr,
    input logic              o_mem_wr_last
);

    int n_fail = 0;    // failed property count

    // memory sees whole lines only
    a_rd_aligned: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_rd_req |-> (o_mem_rd_addr[dcache_pkg::DC_OFF_W-1:0] == '0))
        else begin
            $error("memory read address is not line-aligned");
            n_fail++;
        end

    a_wr_aligned: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_wr_valid |-> (o_mem_wr_addr[dcache_pkg::DC_OFF_W-1:0] == '0))
        else begin
            $error("memory write address is not line-aligned");
            n_fail++;
        end

    a_one_ready: assert property (@(posedge clk) disable iff (!rstn)
        !(o_rready && o_wready))
        else begin
            $error("load and store ready high together");
            n_fail++;
        end

    a_last_valid: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_wr_last |-> o_mem_wr_valid)
        else begin
            $error("write last without write valid");
            n_fail++;
        end

    a_rready_valid: assert property (@(posedge clk) disable iff (!rstn)
        o_rready |-> i_rvalid)
        else begin
            $error("load ready without a load request");
            n_fail++;
        end

    a_wready_valid: assert property (@(posedge clk) disable iff (!rstn)
        o_wready |-> i_wvalid)
        else begin
            $error("store ready without a store request");
            n_fail++;
        end

endmodule

bind dcache_top dcache_props i_props (
    .clk            (clk),
    .rstn           (rstn),
    .i_rvalid       (i_rvalid),
    .i_wvalid       (i_wvalid),
    .o_rready       (o_rready),
    .o_wready       (o_wready),
    .o_mem_rd_req   (o_mem_rd_req),
    .o_mem_rd_addr  (o_mem_rd_addr),
    .o_mem_wr_valid (o_mem_wr_valid),
    .o_mem_wr_addr  (o_mem_wr_addr),
    .o_mem_wr_last  (o_mem_wr_last)
);

// ==== tb_dcache.sv ====
module tb_dcache;

    localparam int RESET_CYCLES = 16;
    localparam int MISS_BOUND   = 40;              // worst case for one request
    localparam int N_RAND       = 300;
    localparam int N_REQ        = N_RAND + 20;     // directed tests stay below 20
    localparam int SEED         = 32'hc280_e401;

    logic                 clk;
    logic                 rstn;
    logic                 i_rvalid, i_wvalid;
    dcache_pkg::addr_t    i_addr;
    dcache_pkg::word_t    i_wdata;
    dcache_pkg::strb_t    i_wstrb;
    logic                 o_rready, o_wready;
    dcache_pkg::word_t    o_rdata;
    logic                 o_mem_rd_req;
    dcache_pkg::addr_t    o_mem_rd_addr;
    logic                 i_mem_rd_valid, i_mem_rd_last;
    dcache_pkg::word_t    i_mem_rd_data;
    logic                 o_mem_wr_valid, i_mem_wr_ready, o_mem_wr_last, i_mem_wr_done;
    dcache_pkg::addr_t    o_mem_wr_addr;
    dcache_pkg::word_t    o_mem_wr_data;

    dcache_pkg::word_t    ref_mem [dcache_pkg::addr_t];   // program view
    dcache_pkg::word_t    bk_mem [dcache_pkg::addr_t];    // backing memory
    dcache_pkg::word_t    exp_q [$];
    integer               stim_seed = SEED;
    integer               gap_seed = SEED;
    int                   n_errors, n_checks, n_tests, err_mark;
    int                   prop_seen;
    int                   rd_bursts, wr_beats;
    dcache_pkg::addr_t    last_wb_addr;

    dcache_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic dcache_pkg::word_t fill_word(input dcache_pkg::addr_t a);
        return ((a ^ 32'h5a5a_a5a5) * 32'h9e37_79b9) ^ {a[7:0], a[31:8]};
    endfunction

    // expected load word, stores land byte by byte
    function automatic dcache_pkg::word_t ref_access(input dcache_pkg::addr_t a, input logic we,
                                                     input dcache_pkg::word_t d,
                                                     input dcache_pkg::strb_t s);
        dcache_pkg::addr_t wa;
        dcache_pkg::word_t w;
        wa = {a[31:2], 2'b00};
        w  = ref_mem.exists(wa) ? ref_mem[wa] : fill_word(wa);
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (s[b]) w[8*b +: 8] = d[8*b +: 8];
            end
            ref_mem[wa] = w;
        end
        return w;
    endfunction

    task automatic report_error(input string msg);
        n_errors++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    task automatic check_word(input dcache_pkg::addr_t a, input dcache_pkg::word_t got,
                              input dcache_pkg::word_t exp);
        n_checks++;
        if (got !== exp) report_error($sformatf("load 0x%08h gave 0x%08h, expected 0x%08h",
                                                a, got, exp));
    endtask

    // victim line still matches the program view while it drains
    task automatic check_wb(input dcache_pkg::addr_t a, input dcache_pkg::word_t d);
        dcache_pkg::word_t exp;
        exp = ref_access(a, 1'b0, '0, '0);
        n_checks++;
        if (d !== exp) report_error($sformatf("write-back 0x%08h carried 0x%08h, expected 0x%08h",
                                              a, d, exp));
    endtask

    task automatic check_addr(input dcache_pkg::addr_t got, input dcache_pkg::addr_t exp);
        n_checks++;
        if (got !== exp) report_error($sformatf("victim line 0x%08h, expected 0x%08h", got, exp));
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        n_checks++;
        if (got != exp) report_error($sformatf("%s: %0d, expected %0d", what, got, exp));
    endtask

    // caller sits on a falling edge, returns on one
    task automatic access(input dcache_pkg::addr_t a, input logic we, input dcache_pkg::word_t d,
                          input dcache_pkg::strb_t s);
        int waited;
        if (!we) exp_q.push_back(ref_access(a, 1'b0, '0, '0));
        else void'(ref_access(a, 1'b1, d, s));
        i_addr   = a;
        i_wdata  = d;
        i_wstrb  = we ? s : '0;
        i_rvalid = !we;
        i_wvalid = we;
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!(we ? o_wready : o_rready) && waited < 2 * MISS_BOUND);
        if (waited >= 2 * MISS_BOUND) begin
            n_errors++;
            $display("%0t: the cache never answered the %s at 0x%08h", $time,
                     we ? "store" : "load", a);
            if (!we) void'(exp_q.pop_back());
        end else begin
            @(negedge clk);                     // handshake edge passed
        end
        i_rvalid = 1'b0;
        i_wvalid = 1'b0;
    endtask

    task automatic load(input dcache_pkg::addr_t a);
        access(a, 1'b0, '0, '0);
    endtask

    task automatic store(input dcache_pkg::addr_t a, input dcache_pkg::word_t d,
                         input dcache_pkg::strb_t s);
        access(a, 1'b1, d, s);
    endtask

    task automatic end_test(input string name);
        // bound property failures count against the test that saw them
        n_errors += i_dut.i_props.n_fail - prop_seen;
        prop_seen = i_dut.i_props.n_fail;
        n_tests++;
        $display("test %0d %s: %s", n_tests, name, (n_errors == err_mark) ? "pass" : "FAIL");
        err_mark = n_errors;
    endtask

    // memory model, random gaps on both bursts
    initial begin
        dcache_pkg::addr_t rd_base;
        int                rd_beat;
        int                wr_beat;
        logic              rd_active;
        logic              done_due;
        i_mem_rd_valid = 1'b0;
        i_mem_rd_last  = 1'b0;
        i_mem_rd_data  = '0;
        i_mem_wr_ready = 1'b0;
        i_mem_wr_done  = 1'b0;
        rd_active      = 1'b0;
        done_due       = 1'b0;
        rd_beat        = 0;
        wr_beat        = 0;
        forever begin
            @(negedge clk);
            i_mem_rd_valid = 1'b0;
            i_mem_rd_last  = 1'b0;
            i_mem_wr_ready = 1'b0;
            i_mem_wr_done  = 1'b0;
            if (o_mem_rd_req === 1'b1 && !rd_active) begin
                rd_active = 1'b1;
                rd_base   = o_mem_rd_addr;
                rd_beat   = 0;
                rd_bursts++;
            end
            if (rd_active && ($random(gap_seed) & 3) != 0) begin
                i_mem_rd_valid = 1'b1;
                i_mem_rd_data  = bk_mem.exists(rd_base + 4 * rd_beat) ?
                                 bk_mem[rd_base + 4 * rd_beat] : fill_word(rd_base + 4 * rd_beat);
                i_mem_rd_last  = (rd_beat == dcache_pkg::DC_WORDS - 1);
                rd_beat++;
                if (rd_beat == dcache_pkg::DC_WORDS) rd_active = 1'b0;
            end
            if (done_due) begin
                if (($random(gap_seed) & 3) != 0) begin
                    i_mem_wr_done = 1'b1;       // single-cycle pulse
                    done_due      = 1'b0;
                end
            end else if (o_mem_wr_valid === 1'b1 && ($random(gap_seed) & 3) != 0) begin
                i_mem_wr_ready = 1'b1;
                last_wb_addr   = o_mem_wr_addr;
                check_wb(o_mem_wr_addr + 4 * wr_beat, o_mem_wr_data);
                if (o_mem_wr_last !== (wr_beat == dcache_pkg::DC_WORDS - 1)) begin
                    report_error($sformatf("write beat %0d has last %b", wr_beat, o_mem_wr_last));
                end
                bk_mem[o_mem_wr_addr + 4 * wr_beat] = o_mem_wr_data;
                wr_beats++;
                wr_beat = (wr_beat + 1) % dcache_pkg::DC_WORDS;
                if (wr_beat == 0) done_due = 1'b1;
            end
        end
    end

    // load results against the reference
    initial begin
        forever begin
            @(negedge clk);
            if (rstn && o_rready) begin
                if (exp_q.size() == 0) begin
                    n_errors++;
                    $display("%0t: load ready with no load outstanding", $time);
                end else begin
                    check_word(i_addr, o_rdata, exp_q.pop_front());
                end
            end
        end
    end

    initial begin
        repeat (RESET_CYCLES + N_REQ * MISS_BOUND) @(posedge clk);
        $display("watchdog expired, the run did not finish in time");
        $display("Errors found");
        $finish;
    end

    initial begin
        int                rd0;
        int                wr0;
        logic [31:0]       r;
        dcache_pkg::addr_t a;
        dcache_pkg::strb_t s;
        rstn     = 1'b0;
        i_rvalid = 1'b0;
        i_wvalid = 1'b0;
        i_addr   = '0;
        i_wdata  = '0;
        i_wstrb  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        load(32'h0000_1030);
        rd0 = rd_bursts;
        load(32'h0000_103c);                    // same line, should hit
        check_count("read bursts on line hit", rd_bursts - rd0, 0);
        end_test("load miss then line hit");

        rd0 = rd_bursts;
        store(32'h0000_1034, 32'ha1b2_c3d4, 4'b0101);
        load(32'h0000_1034);
        check_count("read bursts on store hit", rd_bursts - rd0, 0);
        end_test("partial store hit");

        wr0 = wr_beats;
        load(32'h0000_2050);
        load(32'h0000_3050);
        load(32'h0000_2050);                    // B is now least recent
        load(32'h0000_4050);
        rd0 = rd_bursts;
        load(32'h0000_2050);
        check_count("read bursts after LRU victim", rd_bursts - rd0, 0);
        check_count("write beats for clean victims", wr_beats - wr0, 0);
        end_test("LRU replacement");

        store(32'h0000_5070, 32'hdead_beef, 4'hf);
        store(32'h0000_6074, 32'h1357_9bdf, 4'b1100);
        wr0 = wr_beats;
        load(32'h0000_7070);
        check_count("write beats for dirty victim", wr_beats - wr0, 4);
        check_addr(last_wb_addr, 32'h0000_5070);
        wr0 = wr_beats;
        load(32'h0000_8078);
        check_count("write beats for dirty victim", wr_beats - wr0, 4);
        check_addr(last_wb_addr, 32'h0000_6070);
        wr0 = wr_beats;
        load(32'h0000_9070);
        load(32'h0000_5070);                    // comes back from memory
        check_count("write beats for clean victims", wr_beats - wr0, 0);
        end_test("dirty and clean eviction");

        // sets 8 to 11, four tags each
        for (int i = 0; i < N_RAND; i++) begin
            r = $random(stim_seed);
            a = 32'h0000_a080 | {22'd0, r[5:4], 2'b00, r[3:2], r[1:0], 2'b00};
            s = (r[11:8] == 4'h0) ? 4'hf : r[11:8];
            if (r[6]) store(a, $random(stim_seed), s);
            else load(a);
        end
        end_test("random loads and stores");

        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
dcache_pkg.sv
dcache_ifs.sv
dcache_way_ram.sv
dcache_req_front.sv
dcache_ctrl.sv
dcache_refill.sv
dcache_writeback.sv
dcache_top.sv
dcache_props.sv
tb_dcache.sv
